// File: rd_axi_pkg.sv
/*
 * Protocol limits of the memory-mapped read bus
 * Imported by the command setup, the burst issuer and the top level
 */

package rd_axi_pkg;

  ////////////////////////////////////////
  // Burst limits
  ////////////////////////////////////////

  // Most beats one burst may carry
  localparam int AXI_MAX_BURST_BEATS = 256;

  // Most bytes one burst may span, also the boundary a burst must not cross
  localparam int AXI_MAX_BURST_BYTES = 4096;

  ////////////////////////////////////////
  // Length field
  ////////////////////////////////////////

  // Burst length field holds beats minus one
  localparam int AXI_LEN_W = 8;

endpackage : rd_axi_pkg

// File: rd_burst_issuer.sv
/*
 * Read address channel driver
 * Issues one burst per handshake until the command is used up, and stalls
 * while all outstanding-burst credit is taken
 */

`timescale 1ns/1ps

module rd_burst_issuer import rd_master_pkg::*, rd_axi_pkg::*; (
  input  logic                 aclk,
  input  logic                 areset,
  rd_cmd_if.issuer             cmd,
  output logic                 arvalid,
  input  logic                 arready,
  output logic [ADDR_W-1:0]    araddr,
  output logic [AXI_LEN_W-1:0] arlen,
  input  logic                 burst_drained
);

  logic              ar_hs;
  logic              idle;
  logic              arvalid_r;
  logic [ADDR_W-1:0] addr_r;
  logic              last_burst;
  logic              credit_zero;

  assign ar_hs = arvalid_r & arready;

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  // Bursts left to issue, zero while the last one is on the bus
  rd_updown_counter #(
    .width      (BURST_CNT_W),
    .init_value ('0)
  ) i_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (cmd.load),
    .incr       (1'b0),
    .decr       (ar_hs),
    .load_value (cmd.full_bursts),
    .count      (),
    .is_zero    (last_burst)
  );

  // One credit per burst the FIFO can still take
  // Taken at each handshake, returned when a burst end leaves the stream
  rd_updown_counter #(
    .width      (CREDIT_CNT_W),
    .init_value (CREDIT_CNT_W'(MAX_OUTSTANDING))
  ) i_credit_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_drained),
    .decr       (ar_hs),
    .load_value ('0),
    .count      (),
    .is_zero    (credit_zero)
  );

  ////////////////////////////////////////
  // Address channel control
  ////////////////////////////////////////

  // Busy from load until the last burst is accepted
  always_ff @(posedge aclk) begin
    if (areset) begin
      idle <= 1'b1;
    end else if (cmd.load) begin
      idle <= 1'b0;
    end else if (ar_hs && last_burst) begin
      idle <= 1'b1;
    end
  end

  // Valid drops for one cycle after every handshake
  // so the credit and burst counts are current before the next request
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid_r <= 1'b0;
    end else if (!arvalid_r && !idle && !credit_zero) begin
      arvalid_r <= 1'b1;
    end else if (arready) begin
      arvalid_r <= 1'b0;
    end
  end

  // Running burst address
  always_ff @(posedge aclk) begin
    if (cmd.load) begin
      addr_r <= cmd.base_addr;
    end else if (ar_hs) begin
      addr_r <= addr_r + ADDR_W'(BURST_BYTES);
    end
  end

  assign arvalid = arvalid_r;
  assign araddr  = addr_r;
  // Full bursts carry the maximum length field
  assign arlen   = last_burst ? cmd.final_len : AXI_LEN_W'(BURST_BEATS - 1);

endmodule : rd_burst_issuer

// File: rd_cmd_if.sv
/*
 * Prepared transfer command
 * Driven by the command setup, read by the burst issuer and the done tracker
 */

`timescale 1ns/1ps

interface rd_cmd_if import rd_master_pkg::*, rd_axi_pkg::*; ();

  // One-cycle pulse that starts a transfer
  logic                   load;
  // Burst-aligned first address
  logic [ADDR_W-1:0]      base_addr;
  // Number of bursts minus one
  logic [BURST_CNT_W-1:0] full_bursts;
  // Length field of the last burst
  logic [AXI_LEN_W-1:0]   final_len;

  modport setup   (output load, output base_addr, output full_bursts, output final_len);
  modport issuer  (input load, input base_addr, input full_bursts, input final_len);
  modport tracker (input load, input full_bursts);

endinterface : rd_cmd_if

// File: rd_cmd_setup.sv
/*
 * Samples a read request on the start pulse
 * Rounds the byte count up to whole beats, aligns the address to a burst span
 * and splits the beat count into full bursts and a final burst length
 */

`timescale 1ns/1ps

module rd_cmd_setup import rd_master_pkg::*, rd_axi_pkg::*; (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   start,
  input  logic [ADDR_W-1:0]      addr_offset,
  input  logic [XFER_SIZE_W-1:0] xfer_size,
  rd_cmd_if.setup                cmd
);

  logic                   start_d1;
  logic                   load_r;
  logic [TOTAL_LEN_W-1:0] size_beats;
  logic [TOTAL_LEN_W-1:0] total_len_r;
  logic [ADDR_W-1:0]      base_addr_r;
  logic [BURST_CNT_W-1:0] full_bursts_r;
  logic [AXI_LEN_W-1:0]   final_len_r;

  // Whole beats in the byte count, truncated
  assign size_beats = xfer_size[XFER_SIZE_W-1:LOG_DATA_BYTES];

  ////////////////////////////////////////
  // Start pulse delay
  ////////////////////////////////////////

  // Two stages give total_len_r and the split fields time to settle
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      load_r   <= 1'b0;
    end else begin
      start_d1 <= start;
      load_r   <= start_d1;
    end
  end

  ////////////////////////////////////////
  // Request capture and split
  ////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (start) begin
      // Beats minus one, rounded up when the count ends in a partial beat
      total_len_r <= (xfer_size[LOG_DATA_BYTES-1:0] != '0) ? size_beats
                                                           : size_beats - 1'b1;
      // Clear the low bits so no burst crosses a protocol boundary
      base_addr_r <= addr_offset & ~BURST_ADDR_MASK;
    end
    if (start_d1) begin
      // Upper bits count bursts, lower bits give the last burst length
      full_bursts_r <= total_len_r[TOTAL_LEN_W-1:LOG_BURST_BEATS];
      final_len_r   <= AXI_LEN_W'(total_len_r[LOG_BURST_BEATS-1:0]);
    end
  end

  assign cmd.load        = load_r;
  assign cmd.base_addr   = base_addr_r;
  assign cmd.full_bursts = full_bursts_r;
  assign cmd.final_len   = final_len_r;

endmodule : rd_cmd_setup

// File: rd_data_fifo.sv
/*
 * First-word-fall-through FIFO between the read data channel and the stream
 * Sized for every outstanding burst, so the read channel never stalls
 */

`timescale 1ns/1ps

module rd_data_fifo import rd_master_pkg::*; (
  input  logic              aclk,
  input  logic              areset,
  input  logic              rvalid,
  output logic              rready,
  input  logic [DATA_W-1:0] rdata,
  input  logic              rlast,
  output logic              tvalid,
  input  logic              tready,
  output logic [DATA_W-1:0] tdata,
  output logic              tlast,
  output logic              burst_drained,
  output logic              beat_last_accepted
);

  // Data word with its last flag in the top bit
  logic [DATA_W:0]      mem [FIFO_DEPTH];
  logic [FIFO_ADDR_W:0] wr_ptr;
  logic [FIFO_ADDR_W:0] rd_ptr;
  logic                 rready_r;
  logic                 wr_en;
  logic                 empty;
  logic                 out_valid;
  logic [DATA_W-1:0]    out_data;
  logic                 out_last;
  logic                 out_load;

  // Ready from the first cycle after reset, space is covered by the credit limit
  always_ff @(posedge aclk) begin
    if (areset) begin
      rready_r <= 1'b0;
    end else begin
      rready_r <= 1'b1;
    end
  end

  assign wr_en = rvalid & rready_r;
  // Extra pointer bit keeps a full memory distinct from an empty one
  assign empty = (wr_ptr == rd_ptr);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr[FIFO_ADDR_W-1:0]] <= {rlast, rdata};
    end
  end

  // Refill the output stage when it is empty or being emptied this cycle
  assign out_load = !empty && (!out_valid || tready);

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (out_load) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      out_valid <= 1'b0;
    end else if (out_load) begin
      out_valid <= 1'b1;
    end else if (tready) begin
      out_valid <= 1'b0;
    end
  end

  // Held while tready is low
  always_ff @(posedge aclk) begin
    if (out_load) begin
      {out_last, out_data} <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
    end
  end

  assign rready = rready_r;
  assign tvalid = out_valid;
  assign tdata  = out_data;
  assign tlast  = out_last;

  // Burst end leaving the stream returns a credit
  assign burst_drained      = out_valid & tready & out_last;
  // Burst end arriving from the bus
  assign beat_last_accepted = wr_en & rlast;

endmodule : rd_data_fifo

// File: rd_done_tracker.sv
/*
 * Counts burst ends on the read data channel
 * Pulses done for one cycle after the last beat of the final burst
 */

`timescale 1ns/1ps

module rd_done_tracker import rd_master_pkg::*; (
  input  logic      aclk,
  input  logic      areset,
  rd_cmd_if.tracker cmd,
  input  logic      beat_last_accepted,
  output logic      done
);

  logic final_burst;
  logic done_r;

  // Bursts still to arrive, zero while the final one is in flight
  rd_updown_counter #(
    .width      (BURST_CNT_W),
    .init_value ('0)
  ) i_rx_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (cmd.load),
    .incr       (1'b0),
    .decr       (beat_last_accepted),
    .load_value (cmd.full_bursts),
    .count      (),
    .is_zero    (final_burst)
  );

  // Single-cycle pulse, no two final beats can be adjacent
  always_ff @(posedge aclk) begin
    if (areset) begin
      done_r <= 1'b0;
    end else begin
      done_r <= beat_last_accepted & final_burst;
    end
  end

  assign done = done_r;

endmodule : rd_done_tracker

// File: rd_master_assertions.sv
/*
 * Concurrent protocol checks on the read master top level
 * Attached to the top level by the bind at the end of this file
 */

`timescale 1ns/1ps

module rd_master_assertions import rd_master_pkg::*, rd_axi_pkg::*; (
  input logic                 aclk,
  input logic                 areset,
  input logic                 ctrl_done,
  input logic                 m_axi_arvalid,
  input logic                 m_axi_arready,
  input logic [ADDR_W-1:0]    m_axi_araddr,
  input logic [AXI_LEN_W-1:0] m_axi_arlen,
  input logic                 m_axi_rready,
  input logic                 m_axis_tvalid,
  input logic                 m_axis_tready,
  input logic [DATA_W-1:0]    m_axis_tdata,
  input logic                 m_axis_tlast
);

  // Address request stays put until accepted
  ar_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
    else $error("arvalid dropped or address changed before arready");

  // Stream word held under back-pressure
  t_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else $error("tvalid dropped or stream word changed while tready low");

  done_single: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else $error("ctrl_done high for two cycles");

  // One cycle after reset for the registered ready
  r_ready: assert property (@(posedge aclk) disable iff (areset)
    !$past(areset) |-> m_axi_rready)
    else $error("rready low outside reset");

endmodule : rd_master_assertions

bind rd_master_top rd_master_assertions i_rd_master_assertions (
  .aclk          (aclk),
  .areset        (areset),
  .ctrl_done     (ctrl_done),
  .m_axi_arvalid (m_axi_arvalid),
  .m_axi_arready (m_axi_arready),
  .m_axi_araddr  (m_axi_araddr),
  .m_axi_arlen   (m_axi_arlen),
  .m_axi_rready  (m_axi_rready),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tlast  (m_axis_tlast)
);

// File: rd_master_pkg.sv
/*
 * Sizing of the read master
 * Widths, outstanding-burst limit, FIFO depth and counter widths
 */

package rd_master_pkg;

  import rd_axi_pkg::*;

  // Bus and request widths
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int XFER_SIZE_W = 20;

  localparam int DATA_BYTES     = DATA_W / 8;
  localparam int LOG_DATA_BYTES = $clog2(DATA_BYTES);

  ////////////////////////////////////////
  // Burst geometry
  ////////////////////////////////////////

  // Smaller of the beat limit and the byte limit expressed in beats
  localparam int BURST_BEATS = (AXI_MAX_BURST_BYTES / DATA_BYTES < AXI_MAX_BURST_BEATS) ?
                               AXI_MAX_BURST_BYTES / DATA_BYTES : AXI_MAX_BURST_BEATS;
  localparam int LOG_BURST_BEATS = $clog2(BURST_BEATS);
  localparam int BURST_BYTES     = BURST_BEATS * DATA_BYTES;

  // Low address bits cleared to align a start address to a burst span
  localparam logic [ADDR_W-1:0] BURST_ADDR_MASK = ADDR_W'(BURST_BYTES - 1);

  ////////////////////////////////////////
  // Buffering and counters
  ////////////////////////////////////////

  localparam int MAX_OUTSTANDING = 4;

  // Holds every outstanding burst, rounded up to a power of two
  localparam int FIFO_DEPTH  = 2 ** $clog2(BURST_BEATS * MAX_OUTSTANDING);
  localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

  localparam int TOTAL_LEN_W  = XFER_SIZE_W - LOG_DATA_BYTES;
  localparam int BURST_CNT_W  = TOTAL_LEN_W - LOG_BURST_BEATS;
  localparam int CREDIT_CNT_W = $clog2(MAX_OUTSTANDING + 1);

endpackage : rd_master_pkg

// File: rd_master_top.sv
/*
 * Read-only bus master, top level
 * A start pulse reads a byte range in bursts and returns the words on a stream
 */

`timescale 1ns/1ps

module rd_master_top import rd_master_pkg::*, rd_axi_pkg::*; (
  input  logic                   aclk,
  input  logic                   areset,
  // Control
  input  logic                   ctrl_start,
  output logic                   ctrl_done,
  input  logic [ADDR_W-1:0]      ctrl_addr_offset,
  input  logic [XFER_SIZE_W-1:0] ctrl_xfer_size_in_bytes,
  // Read address channel
  output logic                   m_axi_arvalid,
  input  logic                   m_axi_arready,
  output logic [ADDR_W-1:0]      m_axi_araddr,
  output logic [AXI_LEN_W-1:0]   m_axi_arlen,
  // Read data channel
  input  logic                   m_axi_rvalid,
  output logic                   m_axi_rready,
  input  logic [DATA_W-1:0]      m_axi_rdata,
  input  logic                   m_axi_rlast,
  // Stream output
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output logic [DATA_W-1:0]      m_axis_tdata,
  output logic                   m_axis_tlast
);

  logic burst_drained;
  logic beat_last_accepted;

  rd_cmd_if cmd_if ();

  ////////////////////////////////////////
  // Command path
  ////////////////////////////////////////

  rd_cmd_setup i_cmd_setup (
    .aclk        (aclk),
    .areset      (areset),
    .start       (ctrl_start),
    .addr_offset (ctrl_addr_offset),
    .xfer_size   (ctrl_xfer_size_in_bytes),
    .cmd         (cmd_if.setup)
  );

  rd_burst_issuer i_burst_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .cmd           (cmd_if.issuer),
    .arvalid       (m_axi_arvalid),
    .arready       (m_axi_arready),
    .araddr        (m_axi_araddr),
    .arlen         (m_axi_arlen),
    .burst_drained (burst_drained)
  );

  ////////////////////////////////////////
  // Data path and completion
  ////////////////////////////////////////

  rd_data_fifo i_data_fifo (
    .aclk               (aclk),
    .areset             (areset),
    .rvalid             (m_axi_rvalid),
    .rready             (m_axi_rready),
    .rdata              (m_axi_rdata),
    .rlast              (m_axi_rlast),
    .tvalid             (m_axis_tvalid),
    .tready             (m_axis_tready),
    .tdata              (m_axis_tdata),
    .tlast              (m_axis_tlast),
    .burst_drained      (burst_drained),
    .beat_last_accepted (beat_last_accepted)
  );

  rd_done_tracker i_done_tracker (
    .aclk               (aclk),
    .areset             (areset),
    .cmd                (cmd_if.tracker),
    .beat_last_accepted (beat_last_accepted),
    .done               (ctrl_done)
  );

endmodule : rd_master_top

// File: rd_updown_counter.sv
/*
 * Loadable up/down counter with a zero flag
 * Counts bursts left to issue, bursts left to receive and burst credit
 */

`timescale 1ns/1ps

module rd_updown_counter #(
  parameter int               width      = 8,
  parameter logic [width-1:0] init_value = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic [width-1:0] count,
  output logic             is_zero
);

  logic [width-1:0] count_r;

  // Load wins over counting
  // Increment and decrement in the same cycle leave the value alone
  always_ff @(posedge aclk) begin
    if (areset) begin
      count_r <= init_value;
    end else if (load) begin
      count_r <= load_value;
    end else if (incr && !decr) begin
      count_r <= count_r + 1'b1;
    end else if (decr && !incr) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign count   = count_r;
  assign is_zero = (count_r == '0);

endmodule : rd_updown_counter

// File: run.sh
#!/bin/sh
# Compile and run the read master testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_rd_master \
  -o sim_rd_master > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_rd_master > sim.log 2>&1 || { echo "Simulation stopped early, see sim.log"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "Test failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Test passed"

// File: tb_rd_master.sv
/*
 * Testbench for the read master
 * Random requests against a memory slave model; the address channel, the stream
 * and the done pulse are checked against a model of each transfer
 */

`timescale 1ns/1ps

module tb_rd_master import rd_master_pkg::*, rd_axi_pkg::*; ();

  localparam int NUM_REQ         = 12;
  localparam int MAX_SIZE        = 5000;
  localparam int BURST_SPAN      = 1024;
  localparam int BEATS_PER_BURST = 256;
  localparam int CREDIT_LIMIT    = 4;
  // 12 requests of at most 1250 beats, with stream stalls and bus gaps
  localparam int TIMEOUT_CYCLES  = 120000;

  logic                   aclk;
  logic                   areset;
  logic                   ctrl_start;
  logic                   ctrl_done;
  logic [ADDR_W-1:0]      ctrl_addr_offset;
  logic [XFER_SIZE_W-1:0] ctrl_xfer_size_in_bytes;
  logic                   m_axi_arvalid;
  logic                   m_axi_arready;
  logic [ADDR_W-1:0]      m_axi_araddr;
  logic [AXI_LEN_W-1:0]   m_axi_arlen;
  logic                   m_axi_rvalid;
  logic                   m_axi_rready;
  logic [DATA_W-1:0]      m_axi_rdata;
  logic                   m_axi_rlast;
  logic                   m_axis_tvalid;
  logic                   m_axis_tready;
  logic [DATA_W-1:0]      m_axis_tdata;
  logic                   m_axis_tlast;

  // Expected bursts and stream words, in order
  logic [ADDR_W-1:0] exp_ar_addr [$];
  int                exp_ar_len [$];
  logic [DATA_W-1:0] exp_data [$];
  logic              exp_last [$];
  // Bursts accepted by the slave and not yet returned
  logic [ADDR_W-1:0] sl_addr [$];
  int                sl_len [$];

  int   beat_idx       = 0;
  int   rx_bursts_left = 0;
  int   done_count     = 0;
  int   outstanding    = 0;
  int   error_count    = 0;
  int   ar_checked     = 0;
  int   beats_checked  = 0;
  int   cycle_count    = 0;
  int   tready_hold    = 0;
  logic tready_level   = 1'b0;
  logic expect_done    = 1'b0;
  logic r_hold         = 1'b0;
  logic run_active     = 1'b0;

  rd_master_top i_rd_master_top (.*);

  initial aclk = 1'b0;
  always #5 aclk = ~aclk;

  always @(posedge aclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Memory content, every address bit shows up in the word
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  // Model of one request, bursts and words derived from offset and size
  task automatic queue_request(input logic [ADDR_W-1:0] offset, input int size);
    logic [ADDR_W-1:0] base;
    int                beats;
    int                bursts;
    int                i;
    base   = offset & ~ADDR_W'(BURST_SPAN - 1);
    beats  = (size + 3) / 4;
    bursts = (beats + BEATS_PER_BURST - 1) / BEATS_PER_BURST;
    for (i = 0; i < bursts; i++) begin
      exp_ar_addr.push_back(base + ADDR_W'(i * BURST_SPAN));
      exp_ar_len.push_back((i == bursts - 1) ? (beats - 1) % BEATS_PER_BURST
                                             : BEATS_PER_BURST - 1);
    end
    for (i = 0; i < beats; i++) begin
      exp_data.push_back(mem_word(base + ADDR_W'(i * 4)));
      exp_last.push_back((i % BEATS_PER_BURST == BEATS_PER_BURST - 1) || (i == beats - 1));
    end
    rx_bursts_left = bursts;
  endtask

  task automatic check_address;
    if (exp_ar_addr.size() == 0) begin
      $display("Address handshake at %0t with no burst expected", $time);
      error_count++;
    end else begin
      if (m_axi_araddr !== exp_ar_addr[0] || int'(m_axi_arlen) != exp_ar_len[0]) begin
        $display("MISMATCH at %0t: araddr %h arlen %0d, expected %h and %0d", $time,
                 m_axi_araddr, m_axi_arlen, exp_ar_addr[0], exp_ar_len[0]);
        error_count++;
      end
      void'(exp_ar_addr.pop_front());
      void'(exp_ar_len.pop_front());
      ar_checked++;
    end
    // Slave answers whatever the bus asked for
    sl_addr.push_back(m_axi_araddr);
    sl_len.push_back(int'(m_axi_arlen));
    outstanding++;
    if (outstanding > CREDIT_LIMIT) begin
      $display("More than %0d bursts outstanding at %0t", CREDIT_LIMIT, $time);
      error_count++;
    end
  endtask

  task automatic check_stream_beat;
    if (exp_data.size() == 0) begin
      $display("Stream beat at %0t with no word expected", $time);
      error_count++;
    end else begin
      if (m_axis_tdata !== exp_data[0] || m_axis_tlast !== exp_last[0]) begin
        $display("MISMATCH at %0t: tdata %h tlast %b, expected %h and %b", $time,
                 m_axis_tdata, m_axis_tlast, exp_data[0], exp_last[0]);
        error_count++;
      end
      void'(exp_data.pop_front());
      void'(exp_last.pop_front());
      beats_checked++;
    end
    if (m_axis_tlast === 1'b1) begin
      outstanding--;
    end
  endtask

  ////////////////////////////////////////
  // Slave model and stream sink
  ////////////////////////////////////////

  // Handshakes predicted here happen at the next rising edge
  always @(negedge aclk) begin
    if (run_active) begin
      if (ctrl_done !== expect_done) begin
        $display("MISMATCH at %0t: ctrl_done %b, expected %b", $time, ctrl_done, expect_done);
        error_count++;
      end
      if (ctrl_done === 1'b1) begin
        done_count++;
      end
      expect_done = 1'b0;
      // Read data first, so no beat leads its own address
      if (!r_hold) begin
        if (sl_addr.size() != 0 && ($urandom % 4 != 0)) begin
          m_axi_rvalid = 1'b1;
          m_axi_rdata  = mem_word(sl_addr[0] + ADDR_W'(beat_idx * 4));
          m_axi_rlast  = (beat_idx == sl_len[0]);
        end else begin
          m_axi_rvalid = 1'b0;
        end
      end
      r_hold = m_axi_rvalid && !m_axi_rready;
      if (m_axi_rvalid && m_axi_rready) begin
        if (m_axi_rlast) begin
          void'(sl_addr.pop_front());
          void'(sl_len.pop_front());
          beat_idx = 0;
          rx_bursts_left--;
          expect_done = (rx_bursts_left == 0);
        end else begin
          beat_idx++;
        end
      end
      // Ready mostly high, now and then low for a long stretch
      if (tready_hold == 0) begin
        tready_level = ($urandom % 8 != 0);
        tready_hold  = tready_level ? 1 + $urandom % 8 : 16 + $urandom % 48;
      end
      m_axis_tready = tready_level;
      tready_hold--;
      if (m_axis_tvalid && m_axis_tready) begin
        check_stream_beat();
      end
      m_axi_arready = ($urandom % 4 == 0);
      if (m_axi_arvalid && m_axi_arready) begin
        check_address();
      end
    end
  end

  ////////////////////////////////////////
  // Reset and requests
  ////////////////////////////////////////

  initial begin
    int                req;
    int                size;
    logic [ADDR_W-1:0] offset;
    void'($urandom(14163));
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    m_axi_arready           = 1'b0;
    m_axi_rvalid            = 1'b0;
    m_axi_rdata             = '0;
    m_axi_rlast             = 1'b0;
    m_axis_tready           = 1'b0;
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    if (m_axi_arvalid !== 1'b0 || m_axis_tvalid !== 1'b0 || ctrl_done !== 1'b0) begin
      $display("MISMATCH at %0t: arvalid %b tvalid %b ctrl_done %b in reset, expected 0",
               $time, m_axi_arvalid, m_axis_tvalid, ctrl_done);
      error_count++;
    end
    areset = 1'b0;
    @(posedge aclk);
    run_active = 1'b1;
    @(negedge aclk);
    if (m_axi_rready !== 1'b1) begin
      $display("MISMATCH at %0t: rready %b after reset, expected 1", $time, m_axi_rready);
      error_count++;
    end
    for (req = 0; req < NUM_REQ; req++) begin
      @(posedge aclk);
      // The first request needs five bursts, enough to run out of credit
      size   = (req == 0) ? 1 + CREDIT_LIMIT * BURST_SPAN
                              + $urandom % (MAX_SIZE - CREDIT_LIMIT * BURST_SPAN)
                          : 1 + $urandom % MAX_SIZE;
      offset = $urandom;
      queue_request(offset, size);
      @(negedge aclk);
      ctrl_start              = 1'b1;
      ctrl_addr_offset        = offset;
      ctrl_xfer_size_in_bytes = XFER_SIZE_W'(size);
      @(negedge aclk);
      ctrl_start = 1'b0;
      // Next start only once done has pulsed and the stream is empty
      while (done_count < req + 1 || exp_data.size() != 0) begin
        @(posedge aclk);
      end
    end
    repeat (20) @(posedge aclk);
    if (exp_ar_addr.size() != 0 || sl_addr.size() != 0 || done_count != NUM_REQ) begin
      $display("Run ended with %0d bursts never issued, %0d never returned, %0d done pulses",
               exp_ar_addr.size(), sl_addr.size(), done_count);
      error_count++;
    end
    $display("Summary: %0d requests, %0d bursts, %0d beats checked, %0d errors",
             NUM_REQ, ar_checked, beats_checked, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_rd_master

// File: vlog.f
rd_axi_pkg.sv
rd_master_pkg.sv
rd_cmd_if.sv
rd_updown_counter.sv
rd_cmd_setup.sv
rd_burst_issuer.sv
rd_data_fifo.sv
rd_done_tracker.sv
rd_master_top.sv
rd_master_assertions.sv
tb_rd_master.sv
